// ==== source/exu_settings.svh ====
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// datapath width of the execute stage
`define EXU_XLEN 32

// register file index width, 32 architectural registers
`define EXU_REG_BITS 5

// shift amount field, low bits of the second operand
`define EXU_SHAMT_BITS 5

// the serial shifter takes at most 2**SHAMT_BITS - 1 steps,
// so the step counter is sized from this macro as well

`endif

// ==== source/exu_pkg.sv ====
`default_nettype none
`include "exu_settings.svh"

package exu_pkg;

	typedef logic [`EXU_XLEN-1:0] word_t;
	typedef logic [`EXU_REG_BITS-1:0] reg_index_t;
	typedef logic [`EXU_SHAMT_BITS-1:0] shamt_t;

	// branches reuse SUB, SLT and SLTU for their compare
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLTU = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		ALU_SRA  = 4'd9
	} alu_op_t;

	typedef enum logic [1:0] {
		SRC1_ZERO = 2'd0,
		SRC1_REG1 = 2'd1,
		SRC1_PC   = 2'd2,
		SRC1_CSR  = 2'd3
	} src1_sel_t;

	typedef enum logic [1:0] {
		SRC2_ZERO = 2'd0,
		SRC2_REG2 = 2'd1,
		SRC2_IMM  = 2'd2,
		SRC2_FOUR = 2'd3
	} src2_sel_t;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BGE  = 3'd4,
		BR_BLTU = 3'd5,
		BR_BGEU = 3'd6
	} branch_type_t;

	typedef enum logic [1:0] {
		CSR_NONE = 2'd0,
		CSR_RW   = 2'd1,
		CSR_RS   = 2'd2
	} csr_op_t;

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_SHIFT = 2'd1,
		ST_DONE  = 2'd2
	} exu_state_t;

	typedef struct packed {
		word_t        reg1;
		word_t        reg2;
		word_t        pc;
		word_t        imm;
		word_t        csr_rdata;
		alu_op_t      alu_op;
		src1_sel_t    src1_sel;
		src2_sel_t    src2_sel;
		branch_type_t branch_type;
		csr_op_t      csr_op;
		logic         store;
		logic         wd;
		reg_index_t   wreg;
	} exu_issue_t;

	typedef struct packed {
		word_t      alu_result;
		word_t      mem_wdata;
		word_t      csr_wdata;
		logic       branch_taken;
		logic       mem_wen;
		logic       wd;
		reg_index_t wreg;
	} exu_result_t;

endpackage

`default_nettype wire

// ==== source/exu_operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_operand_select (
	input  wire exu_pkg::exu_issue_t instr_i,
	output exu_pkg::word_t           src1_o,
	output exu_pkg::word_t           src2_o
);
	import exu_pkg::*;

	// link address is pc + 4
	localparam word_t LINK_STEP = word_t'(4);

	// first operand
	always_comb begin
		unique case (instr_i.src1_sel)
			SRC1_ZERO: src1_o = '0;
			SRC1_REG1: src1_o = instr_i.reg1;
			SRC1_PC:   src1_o = instr_i.pc;
			SRC1_CSR:  src1_o = instr_i.csr_rdata;
			default:   src1_o = '0;
		endcase
	end

	// second operand, low bits double as shift amount
	always_comb begin
		unique case (instr_i.src2_sel)
			SRC2_ZERO: src2_o = '0;
			SRC2_REG2: src2_o = instr_i.reg2;
			SRC2_IMM:  src2_o = instr_i.imm;
			SRC2_FOUR: src2_o = LINK_STEP;
			default:   src2_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exu_settings.svh"

module exu_alu (
	input  wire exu_pkg::alu_op_t op_i,
	input  wire exu_pkg::word_t   src1_i,
	input  wire exu_pkg::word_t   src2_i,
	output exu_pkg::word_t        result_o,
	output logic                  zero_o,
	output logic                  less_o
);
	import exu_pkg::*;

	word_t diff;
	logic  borrow;
	logic  less_signed;
	logic  less_unsigned;
	word_t sum;

	assign sum = src1_i + src2_i;

	// one subtractor serves SUB, the compares and the branch flags
	assign {borrow, diff} = {1'b0, src1_i} - {1'b0, src2_i};

	assign less_unsigned = borrow;

	// differing signs decide directly, otherwise the difference sign does
	always_comb begin
		if (src1_i[`EXU_XLEN-1] != src2_i[`EXU_XLEN-1]) begin
			less_signed = src1_i[`EXU_XLEN-1];
		end else begin
			less_signed = diff[`EXU_XLEN-1];
		end
	end

	assign zero_o = (diff == '0);

	// BLTU and BGEU arrive decoded as SLTU
	assign less_o = (op_i == ALU_SLTU) ? less_unsigned : less_signed;

	always_comb begin
		unique case (op_i)
			ALU_ADD:  result_o = sum;
			ALU_SUB:  result_o = diff;
			ALU_AND:  result_o = src1_i & src2_i;
			ALU_OR:   result_o = src1_i | src2_i;
			ALU_XOR:  result_o = src1_i ^ src2_i;
			ALU_SLT:  result_o = word_t'(less_signed);
			ALU_SLTU: result_o = word_t'(less_unsigned);
			// shifts are produced by the serial shifter
			default:  result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/exu_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exu_settings.svh"

module exu_shifter (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   load_i,
	input  wire                   step_i,
	input  wire exu_pkg::alu_op_t op_i,
	input  wire exu_pkg::word_t   value_i,
	output exu_pkg::word_t        value_o
);
	import exu_pkg::*;

	word_t value_q;
	word_t shifted;

	// one bit position per step
	always_comb begin
		unique case (op_i)
			ALU_SLL: shifted = {value_q[`EXU_XLEN-2:0], 1'b0};
			ALU_SRL: shifted = {1'b0, value_q[`EXU_XLEN-1:1]};
			// arithmetic right keeps the sign bit
			ALU_SRA: shifted = {value_q[`EXU_XLEN-1], value_q[`EXU_XLEN-1:1]};
			default: shifted = value_q;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			value_q <= '0;
		end else if (load_i) begin
			value_q <= value_i;
		end else if (step_i) begin
			value_q <= shifted;
		end
	end

	assign value_o = value_q;

endmodule

`default_nettype wire

// ==== source/exu_step_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_step_counter (
	input  wire                  clock,
	input  wire                  reset,
	input  wire                  load_i,
	input  wire exu_pkg::shamt_t amount_i,
	input  wire                  step_i,
	output logic                 zero_o
);
	import exu_pkg::*;

	shamt_t count_q;
	shamt_t count_d;

	always_comb begin
		count_d = count_q;
		if (load_i) begin
			count_d = amount_i;
		end else if (step_i) begin
			count_d = count_q - shamt_t'(1);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			count_q <= '0;
		end else begin
			count_q <= count_d;
		end
	end

	// flags the count as it will be after this edge, so a load of zero shows at once
	assign zero_o = (count_d == '0);

endmodule

`default_nettype wire

// ==== source/exu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_control (
	input  wire  clock,
	input  wire  reset,
	input  wire  issue_i,
	input  wire  is_shift_i,
	input  wire  count_zero_i,
	output logic accept_o,
	output logic load_o,
	output logic step_o,
	output logic busy_o,
	output logic done_o
);
	import exu_pkg::*;

	exu_state_t state_q;
	exu_state_t state_d;
	logic       pending_q;

	// new work only when nothing is in flight
	assign accept_o = issue_i && (state_q == ST_IDLE) && !pending_q;

	// instruction is latched, operands are ready one cycle later
	assign load_o = pending_q;
	assign step_o = (state_q == ST_SHIFT);
	assign done_o = (state_q == ST_DONE);
	assign busy_o = pending_q || (state_q != ST_IDLE);

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			ST_IDLE: begin
				if (pending_q) begin
					if (is_shift_i && !count_zero_i) begin
						state_d = ST_SHIFT;
					end else begin
						state_d = ST_DONE;
					end
				end
			end
			// leave once the last step is taken
			ST_SHIFT: begin
				if (count_zero_i) begin
					state_d = ST_DONE;
				end
			end
			ST_DONE: begin
				state_d = ST_IDLE;
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q   <= ST_IDLE;
			pending_q <= 1'b0;
		end else begin
			state_q   <= state_d;
			pending_q <= accept_o;
		end
	end

endmodule

`default_nettype wire

// ==== source/exu_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_resolve (
	input  wire exu_pkg::exu_issue_t instr_i,
	input  wire                      zero_i,
	input  wire                      less_i,
	output logic                     branch_taken_o,
	output exu_pkg::word_t           csr_wdata_o,
	output logic                     mem_wen_o,
	output exu_pkg::word_t           mem_wdata_o
);
	import exu_pkg::*;

	// signedness of less_i was already picked by the alu op
	always_comb begin
		unique case (instr_i.branch_type)
			BR_NONE: branch_taken_o = 1'b0;
			BR_BEQ:  branch_taken_o = zero_i;
			BR_BNE:  branch_taken_o = !zero_i;
			BR_BLT:  branch_taken_o = less_i;
			BR_BGE:  branch_taken_o = !less_i;
			BR_BLTU: branch_taken_o = less_i;
			BR_BGEU: branch_taken_o = !less_i;
			default: branch_taken_o = 1'b0;
		endcase
	end

	// csrrs sets the bits of rs1 in the old value
	always_comb begin
		unique case (instr_i.csr_op)
			CSR_RW:  csr_wdata_o = instr_i.reg1;
			CSR_RS:  csr_wdata_o = instr_i.reg1 | instr_i.csr_rdata;
			default: csr_wdata_o = '0;
		endcase
	end

	// store data always comes from rs2
	assign mem_wen_o   = instr_i.store;
	assign mem_wdata_o = instr_i.reg2;

endmodule

`default_nettype wire

// ==== source/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exu_settings.svh"

module exu_top (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      issue_i,
	input  wire exu_pkg::exu_issue_t instr_i,
	output logic                     busy_o,
	output logic                     done_o,
	output exu_pkg::exu_result_t     result_o
);
	import exu_pkg::*;

	exu_issue_t held_q;
	word_t      src1;
	word_t      src2;
	word_t      alu_value;
	word_t      shift_value;
	word_t      csr_wdata;
	word_t      mem_wdata;
	logic       alu_zero;
	logic       alu_less;
	logic       branch_taken;
	logic       mem_wen;
	logic       is_shift;
	logic       accept;
	logic       load;
	logic       step;
	logic       count_zero;

	// holds the accepted instruction until the next issue
	always_ff @(posedge clock) begin
		if (reset) begin
			held_q <= '0;
		end else if (accept) begin
			held_q <= instr_i;
		end
	end

	assign is_shift = (held_q.alu_op == ALU_SLL) || (held_q.alu_op == ALU_SRL) ||
		(held_q.alu_op == ALU_SRA);

	exu_control control_inst (
		.clock       (clock),
		.reset       (reset),
		.issue_i     (issue_i),
		.is_shift_i  (is_shift),
		.count_zero_i(count_zero),
		.accept_o    (accept),
		.load_o      (load),
		.step_o      (step),
		.busy_o      (busy_o),
		.done_o      (done_o)
	);

	exu_operand_select operand_select_inst (
		.instr_i(held_q),
		.src1_o (src1),
		.src2_o (src2)
	);

	exu_step_counter step_counter_inst (
		.clock   (clock),
		.reset   (reset),
		.load_i  (load),
		.amount_i(src2[`EXU_SHAMT_BITS-1:0]),
		.step_i  (step),
		.zero_o  (count_zero)
	);

	exu_shifter shifter_inst (
		.clock  (clock),
		.reset  (reset),
		.load_i (load),
		.step_i (step),
		.op_i   (held_q.alu_op),
		.value_i(src1),
		.value_o(shift_value)
	);

	exu_alu alu_inst (
		.op_i    (held_q.alu_op),
		.src1_i  (src1),
		.src2_i  (src2),
		.result_o(alu_value),
		.zero_o  (alu_zero),
		.less_o  (alu_less)
	);

	exu_resolve resolve_inst (
		.instr_i       (held_q),
		.zero_i        (alu_zero),
		.less_i        (alu_less),
		.branch_taken_o(branch_taken),
		.csr_wdata_o   (csr_wdata),
		.mem_wen_o     (mem_wen),
		.mem_wdata_o   (mem_wdata)
	);

	// stays put after done until the next accept
	always_comb begin
		result_o.alu_result   = is_shift ? shift_value : alu_value;
		result_o.mem_wdata    = mem_wdata;
		result_o.csr_wdata    = csr_wdata;
		result_o.branch_taken = branch_taken;
		result_o.mem_wen      = mem_wen;
		result_o.wd           = held_q.wd;
		result_o.wreg         = held_q.wreg;
	end

endmodule

`default_nettype wire

// ==== testbench/exu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_checker (
	input wire                       clock,
	input wire                       reset,
	input wire                       issue_i,
	input wire                       busy_i,
	input wire                       done_i,
	input wire exu_pkg::exu_result_t result_i
);

	// one instruction in flight, nothing queues
	assert property (@(posedge clock) disable iff (reset) issue_i |-> !busy_i)
		else $error("issue_i asserted while busy_o is high");

	assert property (@(posedge clock) disable iff (reset) done_i |=> !done_i)
		else $error("done_o held longer than one cycle");

	// registers come out of reset idle
	assert property (@(posedge clock) reset |=> (!busy_i && !done_i))
		else $error("busy_o or done_o high after reset");

	// result holds between completion and the next issue
	assert property (@(posedge clock) disable iff (reset)
		(!issue_i && !busy_i) |=> $stable(result_i))
		else $error("result_o changed while idle");

endmodule

bind exu_top exu_checker checker_inst (
	.clock   (clock),
	.reset   (reset),
	.issue_i (issue_i),
	.busy_i  (busy_o),
	.done_i  (done_o),
	.result_i(result_o)
);

`default_nettype wire

// ==== testbench/exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_tb;
	import exu_pkg::*;

	logic        clock;
	logic        reset;
	logic        issue;
	exu_issue_t  instr;
	logic        busy;
	logic        done;
	exu_result_t result;
	integer      seed;

	exu_top exu_inst (
		.clock   (clock),
		.reset   (reset),
		.issue_i (issue),
		.instr_i (instr),
		.busy_o  (busy),
		.done_o  (done),
		.result_o(result)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic fail_value(input string name, input word_t got, input word_t exp);
		stop_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
	endtask

	function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b);
		case (op)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			// shift amount is the low five bits of the second operand
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			ALU_SRA:  return $signed(a) >>> b[4:0];
			default:  return '0;
		endcase
	endfunction

	function automatic logic model_taken(input branch_type_t br, input word_t a, input word_t b);
		case (br)
			BR_BEQ:  return a == b;
			BR_BNE:  return a != b;
			BR_BLT:  return $signed(a) < $signed(b);
			BR_BGE:  return $signed(a) >= $signed(b);
			BR_BLTU: return a < b;
			BR_BGEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// random data fields, plain add of reg1 and reg2
	function automatic exu_issue_t random_instr();
		logic [191:0] raw;
		exu_issue_t   i;
		for (int w = 0; w < 6; w++) begin
			raw[w*32 +: 32] = $random(seed);
		end
		i = exu_issue_t'(raw[$bits(exu_issue_t)-1:0]);
		i.alu_op      = ALU_ADD;
		i.src1_sel    = SRC1_REG1;
		i.src2_sel    = SRC2_REG2;
		i.branch_type = BR_NONE;
		i.csr_op      = CSR_NONE;
		return i;
	endfunction

	task automatic execute(input exu_issue_t i);
		word_t srcs1[4];
		word_t srcs2[4];
		word_t a;
		word_t b;
		word_t exp_alu;
		word_t exp_csr;
		logic  shift_op;
		int    lat;
		int    exp_lat;
		srcs1 = '{32'h0, i.reg1, i.pc, i.csr_rdata};
		srcs2 = '{32'h0, i.reg2, i.imm, 32'h4};
		a = srcs1[i.src1_sel];
		b = srcs2[i.src2_sel];
		shift_op = (i.alu_op == ALU_SLL) || (i.alu_op == ALU_SRL) || (i.alu_op == ALU_SRA);
		exp_lat = shift_op ? 1 + int'(b[4:0]) : 1;
		exp_alu = model_alu(i.alu_op, a, b);
		exp_csr = (i.csr_op == CSR_RW) ? i.reg1 :
			(i.csr_op == CSR_RS) ? (i.reg1 | i.csr_rdata) : '0;
		@(posedge clock);
		#1;
		assert (!busy) else stop_run("busy_o still high when a new issue is due");
		instr = i;
		issue = 1'b1;
		// accepting edge counts as zero
		lat = -1;
		while (!done) begin
			@(posedge clock);
			#1;
			issue = 1'b0;
			lat++;
			if (lat > 40) begin
				stop_run("done_o did not arrive within 40 cycles of an issue");
			end
			assert (busy) else stop_run("busy_o low while an instruction is in flight");
		end
		assert (lat == exp_lat)
			else stop_run($sformatf("done_o came %0d cycles after accept, not %0d", lat, exp_lat));
		assert (result.alu_result == exp_alu)
			else fail_value("alu_result", result.alu_result, exp_alu);
		assert (result.branch_taken == model_taken(i.branch_type, a, b))
			else fail_value("branch_taken", word_t'(result.branch_taken),
				word_t'(model_taken(i.branch_type, a, b)));
		assert (result.csr_wdata == exp_csr)
			else fail_value("csr_wdata", result.csr_wdata, exp_csr);
		assert (result.mem_wdata == i.reg2)
			else fail_value("mem_wdata", result.mem_wdata, i.reg2);
		assert ({result.mem_wen, result.wd, result.wreg} == {i.store, i.wd, i.wreg})
			else fail_value("mem_wen/wd/wreg", word_t'({result.mem_wen, result.wd, result.wreg}),
				word_t'({i.store, i.wd, i.wreg}));
	endtask

	task automatic test_arith();
		alu_op_t    ops[5] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
		exu_issue_t i;
		foreach (ops[n]) begin
			// every pair of operand sources, pc + four among them
			for (int s = 0; s < 16; s++) begin
				i = random_instr();
				i.alu_op   = ops[n];
				i.src1_sel = src1_sel_t'(s[3:2]);
				i.src2_sel = src2_sel_t'(s[1:0]);
				execute(i);
			end
		end
	endtask

	task automatic test_compare();
		word_t      bounds[5] = '{32'h8000_0000, 32'h7fff_ffff, 32'h0, 32'hffff_ffff, 32'h1};
		exu_issue_t i;
		foreach (bounds[x]) begin
			foreach (bounds[y]) begin
				i = random_instr();
				i.reg1   = bounds[x];
				i.reg2   = bounds[y];
				i.alu_op = ALU_SLT;
				execute(i);
				i.alu_op = ALU_SLTU;
				execute(i);
			end
		end
	endtask

	task automatic test_branch();
		// equal, signed less, unsigned less, greater
		word_t      lhs[4] = '{32'h5, 32'h8000_0000, 32'h1, 32'h7};
		word_t      rhs[4] = '{32'h5, 32'h1, 32'h8000_0000, 32'h3};
		exu_issue_t i;
		for (int t = 0; t < 7; t++) begin
			foreach (lhs[p]) begin
				i = random_instr();
				i.reg1        = lhs[p];
				i.reg2        = rhs[p];
				i.branch_type = branch_type_t'(t[2:0]);
				case (i.branch_type)
					BR_BLT, BR_BGE:   i.alu_op = ALU_SLT;
					BR_BLTU, BR_BGEU: i.alu_op = ALU_SLTU;
					default:          i.alu_op = ALU_SUB;
				endcase
				execute(i);
			end
		end
	endtask

	task automatic test_shift();
		alu_op_t    ops[3] = '{ALU_SLL, ALU_SRL, ALU_SRA};
		word_t      r;
		exu_issue_t i;
		foreach (ops[n]) begin
			for (int m = 0; m < 6; m++) begin
				i = random_instr();
				r = $random(seed);
				i.alu_op   = ops[n];
				i.src2_sel = SRC2_IMM;
				// upper imm bits must not reach the amount
				case (m)
					0:       i.imm = {r[31:5], 5'd0};
					1:       i.imm = {r[31:5], 5'd1};
					2:       i.imm = {r[31:5], 5'd31};
					default: i.imm = r;
				endcase
				if (m == 2) begin
					i.reg1[31] = 1'b1;
				end
				execute(i);
			end
		end
	endtask

	task automatic test_csr_store();
		csr_op_t    ops[3] = '{CSR_NONE, CSR_RW, CSR_RS};
		exu_issue_t i;
		foreach (ops[n]) begin
			for (int st = 0; st < 2; st++) begin
				i = random_instr();
				i.csr_op   = ops[n];
				i.src1_sel = SRC1_CSR;
				i.store    = st[0];
				execute(i);
			end
		end
	endtask

	task automatic test_back_to_back();
		word_t      r;
		exu_issue_t i;
		for (int n = 0; n < 24; n++) begin
			i = random_instr();
			r = $random(seed);
			i.alu_op   = alu_op_t'(r[3:0] % 4'd10);
			i.src1_sel = src1_sel_t'(r[5:4]);
			i.src2_sel = src2_sel_t'(r[7:6]);
			i.csr_op   = r[8] ? CSR_RS : CSR_RW;
			execute(i);
		end
	endtask

	initial begin
		seed  = 32'hb6915309;
		reset = 1'b1;
		issue = 1'b0;
		instr = '0;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		assert (!busy && !done) else stop_run("busy_o or done_o is high right after reset");
		test_arith();
		test_compare();
		test_branch();
		test_shift();
		test_csr_store();
		test_back_to_back();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/exu_pkg.sv
source/exu_operand_select.sv
source/exu_alu.sv
source/exu_shifter.sv
source/exu_step_counter.sv
source/exu_control.sv
source/exu_resolve.sv
source/exu_top.sv
testbench/exu_checker.sv
testbench/exu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module exu_tb -Mdir obj_dir -o exu_sim &&
./obj_dir/exu_sim ||
{ echo "run did not pass"; exit 1; }
